// File: common/mipsPkg.sv
package mipsPkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] regAddr_t;

  // Primary opcode field, instr[31:26]
  typedef enum logic [5:0] {
    opSpecial = 6'h00,
    opJ       = 6'h02,
    opJal     = 6'h03,
    opBeq     = 6'h04,
    opBne     = 6'h05,
    opAddiu   = 6'h09,
    opSlti    = 6'h0a,
    opSltiu   = 6'h0b,
    opAndi    = 6'h0c,
    opOri     = 6'h0d,
    opXori    = 6'h0e,
    opLui     = 6'h0f,
    opLb      = 6'h20,
    opLh      = 6'h21,
    opLw      = 6'h23,
    opLbu     = 6'h24,
    opLhu     = 6'h25,
    opSb      = 6'h28,
    opSh      = 6'h29,
    opSw      = 6'h2b
  } opcode_t;

  // Function field of R-type instructions, instr[5:0]
  typedef enum logic [5:0] {
    fnSll  = 6'h00,
    fnSrl  = 6'h02,
    fnSra  = 6'h03,
    fnJr   = 6'h08,
    fnAddu = 6'h21,
    fnSubu = 6'h23,
    fnAnd  = 6'h24,
    fnOr   = 6'h25,
    fnXor  = 6'h26,
    fnNor  = 6'h27,
    fnSlt  = 6'h2a,
    fnSltu = 6'h2b
  } funct_t;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
    aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
  } aluOp_t;

  typedef enum logic [1:0] {memByte, memHalf, memWord} memSize_t;

  typedef enum logic [2:0] {brNone, brBeq, brBne, brJump, brJumpReg} branch_t;

  // All-zero value decodes as a NOP
  typedef struct packed {
    aluOp_t   aluOp;
    logic     aluSrcImm;
    logic     zeroExt;
    logic     shiftImm;
    logic     regDstRd;
    logic     link;
    logic     memWrite;
    logic     memToReg;
    logic     loadUnsigned;
    memSize_t memSize;
    logic     regWrite;
    branch_t  branch;
  } ctrl_t;

endpackage

// File: common/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Instruction memory depth in words, as log2
`define IMEM_WORDS_LOG2 10

// Data memory depth in words, as log2
`define DMEM_WORDS_LOG2 10

// Stores with this address bit set go to the output port
`define IO_ADDR_BIT 31

`endif

// File: common/pipeIf.sv
`timescale 1ns/1ps

// Execute to memory bundle
interface exMemIf;
  mipsPkg::ctrl_t ctrl;
  mipsPkg::word_t aluOut;
  mipsPkg::word_t storeData;
  logic [3:0] byteMask;
  mipsPkg::regAddr_t writeReg;
  // Unregistered execute-stage address, used for the synchronous data read
  mipsPkg::word_t readAddr;

  modport src(output ctrl, aluOut, storeData, byteMask, writeReg, readAddr);
  modport dst(input ctrl, aluOut, storeData, byteMask, writeReg, readAddr);
endinterface

// Register write and forwarding path back to execute
interface wbIf;
  logic regWrite;
  mipsPkg::regAddr_t writeReg;
  mipsPkg::word_t result;
  logic fwdValid;
  mipsPkg::word_t fwdData;

  modport src(output regWrite, writeReg, result, fwdValid, fwdData);
  modport dst(input regWrite, writeReg, result, fwdValid, fwdData);
endinterface

// File: design/executeStage.sv
`timescale 1ns/1ps

module executeStage (
  input  logic clk,
  input  logic rst,
  input  logic stall,
  input  mipsPkg::word_t instrE,
  input  mipsPkg::ctrl_t ctrlE,
  input  mipsPkg::word_t pcE,
  output logic nextPcValid,
  output mipsPkg::word_t nextPc,
  exMemIf.src em,
  wbIf.dst wb
);

  mipsPkg::regAddr_t rs;
  mipsPkg::regAddr_t rt;
  mipsPkg::regAddr_t writeRegE;
  mipsPkg::word_t rdRs;
  mipsPkg::word_t rdRt;
  mipsPkg::word_t opA;
  mipsPkg::word_t opB;
  mipsPkg::word_t immExt;
  mipsPkg::word_t aluB;
  mipsPkg::word_t aluRes;
  mipsPkg::word_t exOut;
  mipsPkg::word_t pcPlus4;
  mipsPkg::word_t laneData;
  logic [4:0] shamt;
  logic [3:0] mask;

  assign rs = instrE[25:21];
  assign rt = instrE[20:16];

  regFile regs (
    .clk(clk),
    .we(wb.regWrite),
    .wa(wb.writeReg),
    .wd(wb.result),
    .ra1(rs),
    .ra2(rt),
    .rd1(rdRs),
    .rd2(rdRt)
  );

  // Forward the ALU result of the instruction in memory
  assign opA = (wb.fwdValid && wb.writeReg == rs && rs != 5'd0) ? wb.fwdData : rdRs;
  assign opB = (wb.fwdValid && wb.writeReg == rt && rt != 5'd0) ? wb.fwdData : rdRt;

  assign immExt = ctrlE.zeroExt ? {16'b0, instrE[15:0]} : {{16{instrE[15]}}, instrE[15:0]};
  assign aluB = ctrlE.aluSrcImm ? immExt : opB;
  assign shamt = ctrlE.shiftImm ? instrE[10:6] : opA[4:0];

  always_comb begin
    case (ctrlE.aluOp)
      mipsPkg::aluAdd:  aluRes = opA + aluB;
      mipsPkg::aluSub:  aluRes = opA - aluB;
      mipsPkg::aluAnd:  aluRes = opA & aluB;
      mipsPkg::aluOr:   aluRes = opA | aluB;
      mipsPkg::aluXor:  aluRes = opA ^ aluB;
      mipsPkg::aluNor:  aluRes = ~(opA | aluB);
      mipsPkg::aluSlt:  aluRes = {31'b0, $signed(opA) < $signed(aluB)};
      mipsPkg::aluSltu: aluRes = {31'b0, opA < aluB};
      mipsPkg::aluSll:  aluRes = aluB << shamt;
      mipsPkg::aluSrl:  aluRes = aluB >> shamt;
      mipsPkg::aluSra:  aluRes = $unsigned($signed(aluB) >>> shamt);
      mipsPkg::aluLui:  aluRes = {aluB[15:0], 16'b0};
      default:          aluRes = '0;
    endcase
  end

  assign pcPlus4 = pcE + 32'd4;
  // JAL returns past its delay slot
  assign exOut = ctrlE.link ? pcE + 32'd8 : aluRes;
  assign writeRegE = ctrlE.link ? 5'd31 : (ctrlE.regDstRd ? instrE[15:11] : rt);

  always_comb begin
    nextPc = pcPlus4 + {immExt[29:0], 2'b00};
    case (ctrlE.branch)
      mipsPkg::brBeq: nextPcValid = (opA == opB);
      mipsPkg::brBne: nextPcValid = (opA != opB);
      mipsPkg::brJump: begin
        nextPcValid = 1'b1;
        nextPc = {pcPlus4[31:28], instrE[25:0], 2'b00};
      end
      mipsPkg::brJumpReg: begin
        nextPcValid = 1'b1;
        nextPc = opA;
      end
      default: nextPcValid = 1'b0;
    endcase
  end

  // Byte lanes, with the data replicated so each lane sees its part
  always_comb begin
    case (ctrlE.memSize)
      mipsPkg::memWord: begin
        mask = 4'b1111;
        laneData = opB;
      end
      mipsPkg::memHalf: begin
        mask = aluRes[1] ? 4'b1100 : 4'b0011;
        laneData = {2{opB[15:0]}};
      end
      default: begin
        mask = 4'b0001 << aluRes[1:0];
        laneData = {4{opB[7:0]}};
      end
    endcase
    if (!ctrlE.memWrite) begin
      mask = 4'b0000;
    end
  end

  assign em.readAddr = aluRes;

  always_ff @(posedge clk) begin
    if (rst) begin
      em.ctrl <= '0;
      em.byteMask <= '0;
    end else if (!stall) begin
      em.ctrl <= ctrlE;
      em.byteMask <= mask;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      em.aluOut <= exOut;
      em.storeData <= laneData;
      em.writeReg <= writeRegE;
    end
  end

endmodule

// File: design/fetchStage.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module fetchStage (
  input  logic clk,
  input  logic rst,
  input  logic stall,
  input  logic progWe,
  input  logic [`IMEM_WORDS_LOG2-1:0] progAddr,
  input  mipsPkg::word_t progData,
  input  logic nextPcValid,
  input  mipsPkg::word_t nextPc,
  output mipsPkg::word_t instrE,
  output mipsPkg::ctrl_t ctrlE,
  output mipsPkg::word_t pcE
);

  // pc holds the address of the word now in decode
  mipsPkg::word_t pc;
  mipsPkg::word_t fetchAddr;
  mipsPkg::word_t instrD;
  mipsPkg::ctrl_t ctrlD;
  mipsPkg::word_t imem [2**`IMEM_WORDS_LOG2];

  always_comb begin
    if (rst) begin
      fetchAddr = '0;
    end else if (stall) begin
      // Re-read the same word so decode keeps its instruction
      fetchAddr = pc;
    end else if (nextPcValid) begin
      fetchAddr = nextPc;
    end else begin
      fetchAddr = pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= fetchAddr;
    end
  end

  // Program load port, open only while the core is in reset
  always_ff @(posedge clk) begin
    if (rst && progWe) begin
      imem[progAddr] <= progData;
    end
    instrD <= imem[fetchAddr[`IMEM_WORDS_LOG2+1:2]];
  end

  instrDecoder decoder (
    .instr(instrD),
    .ctrl(ctrlD)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlE <= '0;
    end else if (!stall) begin
      ctrlE <= ctrlD;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      instrE <= instrD;
      pcE <= pc;
    end
  end

  progLoadInReset: assert property (@(posedge clk) progWe |-> rst)
    else $error("progWe asserted outside reset");

endmodule

// File: design/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
  input  mipsPkg::word_t instr,
  output mipsPkg::ctrl_t ctrl
);

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr[31:26];
  assign funct = instr[5:0];

  always_comb begin
    ctrl = '0;
    case (opcode)
      mipsPkg::opSpecial: begin
        ctrl.regDstRd = 1'b1;
        ctrl.regWrite = 1'b1;
        case (funct)
          mipsPkg::fnSll: begin
            ctrl.aluOp = mipsPkg::aluSll;
            ctrl.shiftImm = 1'b1;
          end
          mipsPkg::fnSrl: begin
            ctrl.aluOp = mipsPkg::aluSrl;
            ctrl.shiftImm = 1'b1;
          end
          mipsPkg::fnSra: begin
            ctrl.aluOp = mipsPkg::aluSra;
            ctrl.shiftImm = 1'b1;
          end
          mipsPkg::fnJr: begin
            ctrl.regDstRd = 1'b0;
            ctrl.regWrite = 1'b0;
            ctrl.branch = mipsPkg::brJumpReg;
          end
          mipsPkg::fnAddu: ctrl.aluOp = mipsPkg::aluAdd;
          mipsPkg::fnSubu: ctrl.aluOp = mipsPkg::aluSub;
          mipsPkg::fnAnd:  ctrl.aluOp = mipsPkg::aluAnd;
          mipsPkg::fnOr:   ctrl.aluOp = mipsPkg::aluOr;
          mipsPkg::fnXor:  ctrl.aluOp = mipsPkg::aluXor;
          mipsPkg::fnNor:  ctrl.aluOp = mipsPkg::aluNor;
          mipsPkg::fnSlt:  ctrl.aluOp = mipsPkg::aluSlt;
          mipsPkg::fnSltu: ctrl.aluOp = mipsPkg::aluSltu;
          // Unknown function codes fall back to a NOP
          default: ctrl = '0;
        endcase
      end
      mipsPkg::opJ: ctrl.branch = mipsPkg::brJump;
      mipsPkg::opJal: begin
        ctrl.branch = mipsPkg::brJump;
        ctrl.link = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      mipsPkg::opBeq: ctrl.branch = mipsPkg::brBeq;
      mipsPkg::opBne: ctrl.branch = mipsPkg::brBne;
      mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opSltiu,
      mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLui: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.regWrite = 1'b1;
        case (opcode)
          mipsPkg::opSlti:  ctrl.aluOp = mipsPkg::aluSlt;
          mipsPkg::opSltiu: ctrl.aluOp = mipsPkg::aluSltu;
          mipsPkg::opAndi:  ctrl.aluOp = mipsPkg::aluAnd;
          mipsPkg::opOri:   ctrl.aluOp = mipsPkg::aluOr;
          mipsPkg::opXori:  ctrl.aluOp = mipsPkg::aluXor;
          mipsPkg::opLui:   ctrl.aluOp = mipsPkg::aluLui;
          default:          ctrl.aluOp = mipsPkg::aluAdd;
        endcase
        // Logical immediates are zero extended
        ctrl.zeroExt = (opcode == mipsPkg::opAndi) || (opcode == mipsPkg::opOri) ||
                       (opcode == mipsPkg::opXori);
      end
      mipsPkg::opLb, mipsPkg::opLbu, mipsPkg::opLh, mipsPkg::opLhu, mipsPkg::opLw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.loadUnsigned = (opcode == mipsPkg::opLbu) || (opcode == mipsPkg::opLhu);
        if (opcode == mipsPkg::opLw) begin
          ctrl.memSize = mipsPkg::memWord;
        end else if (opcode == mipsPkg::opLh || opcode == mipsPkg::opLhu) begin
          ctrl.memSize = mipsPkg::memHalf;
        end
      end
      mipsPkg::opSb, mipsPkg::opSh, mipsPkg::opSw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite = 1'b1;
        if (opcode == mipsPkg::opSw) begin
          ctrl.memSize = mipsPkg::memWord;
        end else if (opcode == mipsPkg::opSh) begin
          ctrl.memSize = mipsPkg::memHalf;
        end
      end
      default: ctrl = '0;
    endcase
  end

endmodule

// File: design/memoryStage.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module memoryStage (
  input  logic clk,
  input  logic stall,
  exMemIf.dst em,
  wbIf.src wb,
  output logic ioValid,
  output mipsPkg::word_t ioData
);

  mipsPkg::word_t dmem [2**`DMEM_WORDS_LOG2];
  mipsPkg::word_t readData;
  mipsPkg::word_t loadVal;
  logic [`DMEM_WORDS_LOG2-1:0] wIdx;
  logic [`DMEM_WORDS_LOG2-1:0] rIdx;
  logic [7:0] loadByte;
  logic [15:0] loadHalf;
  logic isIo;
  logic dmemWe;
  logic sameWord;

  assign isIo = em.aluOut[`IO_ADDR_BIT];
  assign dmemWe = em.ctrl.memWrite && !isIo && !stall;
  assign wIdx = em.aluOut[`DMEM_WORDS_LOG2+1:2];
  assign rIdx = em.readAddr[`DMEM_WORDS_LOG2+1:2];
  assign sameWord = (wIdx == rIdx);

  // Write from the memory stage and read for the load now in execute
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (dmemWe && em.byteMask[i]) begin
        dmem[wIdx][8*i +: 8] <= em.storeData[8*i +: 8];
      end
    end
    if (!stall) begin
      for (int i = 0; i < 4; i++) begin
        // Store right before a load to the same word is bypassed
        if (dmemWe && em.byteMask[i] && sameWord) begin
          readData[8*i +: 8] <= em.storeData[8*i +: 8];
        end else begin
          readData[8*i +: 8] <= dmem[rIdx][8*i +: 8];
        end
      end
    end
  end

  assign loadByte = readData[{em.aluOut[1:0], 3'b000} +: 8];
  assign loadHalf = readData[{em.aluOut[1], 4'b0000} +: 16];

  always_comb begin
    case (em.ctrl.memSize)
      mipsPkg::memByte: begin
        loadVal = em.ctrl.loadUnsigned ? {24'b0, loadByte} : {{24{loadByte[7]}}, loadByte};
      end
      mipsPkg::memHalf: begin
        loadVal = em.ctrl.loadUnsigned ? {16'b0, loadHalf} : {{16{loadHalf[15]}}, loadHalf};
      end
      default: loadVal = readData;
    endcase
  end

  assign wb.regWrite = em.ctrl.regWrite && !stall;
  assign wb.writeReg = em.writeReg;
  assign wb.result = em.ctrl.memToReg ? loadVal : em.aluOut;
  // Loads are not forwarded since their data arrives too late
  assign wb.fwdValid = em.ctrl.regWrite && !em.ctrl.memToReg;
  assign wb.fwdData = em.aluOut;

  assign ioValid = em.ctrl.memWrite && isIo && !stall;
  assign ioData = em.storeData;

  // An output port store held by stall goes out on the first free cycle
  heldIoStoreSent: assert property (@(posedge clk)
      (em.ctrl.memWrite && isIo && stall) |=> (stall || ioValid))
    else $error("held I/O store was lost after stall");

endmodule

// File: design/mipsCore.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module mipsCore (
  input  logic clk,
  input  logic rst,
  input  logic stall,
  input  logic progWe,
  input  logic [`IMEM_WORDS_LOG2-1:0] progAddr,
  input  mipsPkg::word_t progData,
  output logic ioValid,
  output mipsPkg::word_t ioData
);

  mipsPkg::word_t instrE;
  mipsPkg::ctrl_t ctrlE;
  mipsPkg::word_t pcE;
  logic nextPcValid;
  mipsPkg::word_t nextPc;

  exMemIf em ();
  wbIf wb ();

  fetchStage fetch (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .progWe(progWe),
    .progAddr(progAddr),
    .progData(progData),
    .nextPcValid(nextPcValid),
    .nextPc(nextPc),
    .instrE(instrE),
    .ctrlE(ctrlE),
    .pcE(pcE)
  );

  executeStage execute (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .instrE(instrE),
    .ctrlE(ctrlE),
    .pcE(pcE),
    .nextPcValid(nextPcValid),
    .nextPc(nextPc),
    .em(em.src),
    .wb(wb.dst)
  );

  memoryStage memory (
    .clk(clk),
    .stall(stall),
    .em(em.dst),
    .wb(wb.src),
    .ioValid(ioValid),
    .ioData(ioData)
  );

endmodule

// File: design/regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic clk,
  input  logic we,
  input  mipsPkg::regAddr_t wa,
  input  mipsPkg::word_t wd,
  input  mipsPkg::regAddr_t ra1,
  input  mipsPkg::regAddr_t ra2,
  output mipsPkg::word_t rd1,
  output mipsPkg::word_t rd2
);

  mipsPkg::word_t regs [32];

  // r0 is never stored
  always_ff @(posedge clk) begin
    if (we && wa != 5'd0) begin
      regs[wa] <= wd;
    end
  end

  assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

  // A write shows on the next read while r0 keeps reading zero
  readAfterWrite: assert property (@(posedge clk)
      we |=> (ra1 != $past(wa) || rd1 == (($past(wa) == 5'd0) ? '0 : $past(wd))))
    else $error("register read does not match the last write");

endmodule

// File: list.f
+incdir+common
common/mipsPkg.sv
common/pipeIf.sv
design/instrDecoder.sv
design/fetchStage.sv
design/regFile.sv
design/executeStage.sv
design/memoryStage.sv
design/mipsCore.sv
tests/mipsCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f list.f --top-module mipsCoreTb \
    -Mdir obj_dir -o mipsCoreTb; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mipsCoreTb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "Simulation PASSED"
exit 0

// File: tests/mipsCoreTb.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module mipsCoreTb;

  localparam int ClockPeriod = 20;
  localparam int NumTests = 5;
  localparam int CyclesPerTest = 400;
  localparam int RunLimit = 300;
  localparam int TailCycles = 20;

  logic clk;
  logic rst;
  logic stall;
  logic progWe;
  logic [`IMEM_WORDS_LOG2-1:0] progAddr;
  mipsPkg::word_t progData;
  logic ioValid;
  mipsPkg::word_t ioData;

  mipsPkg::word_t prog[$];
  mipsPkg::word_t expected[$];
  mipsPkg::word_t captured[$];

  mipsCore i_dut (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .progWe(progWe),
    .progAddr(progAddr),
    .progData(progData),
    .ioValid(ioValid),
    .ioData(ioData)
  );

  always #(ClockPeriod / 2) clk = ~clk;

  task automatic failRun(string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  // Output port monitor sampled on the rising edge
  always @(posedge clk) begin
    if (!rst && ioValid) begin
      if (stall) begin
        failRun("ioValid was high while stall was high");
      end else begin
        captured.push_back(ioData);
      end
    end
  end

  initial begin
    #(NumTests * CyclesPerTest * ClockPeriod);
    failRun("watchdog timeout, the tests did not finish in time");
  end

  task automatic checkWord(string name, mipsPkg::word_t got, mipsPkg::word_t want);
    if (got !== want) begin
      $display("ERROR time %0t %s got %h expected %h", $time, name, got, want);
      failRun("output word mismatch");
    end
  endtask

  task automatic checkCount(string name, int got, int want);
    if (got < want) begin
      failRun($sformatf("%s: only %0d of %0d output strobes arrived", name, got, want));
    end else if (got > want) begin
      failRun($sformatf("%s: %0d more output strobes than expected", name, got - want));
    end
  endtask

  // Instruction encoders
  function automatic mipsPkg::word_t rFormat(mipsPkg::funct_t fn, int rs, int rt, int rd,
                                             int sh);
    return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
  endfunction

  function automatic mipsPkg::word_t iFormat(mipsPkg::opcode_t op, int rs, int rt, int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic mipsPkg::word_t jFormat(mipsPkg::opcode_t op, int index);
    return {op, index[25:0]};
  endfunction

  task automatic emit(mipsPkg::word_t instr);
    prog.push_back(instr);
  endtask

  // r1 holds the I/O base address in every program
  task automatic storeIo(int r);
    emit(iFormat(mipsPkg::opSw, 1, r, 0));
  endtask

  task automatic resultToIo(mipsPkg::word_t instr, mipsPkg::word_t want);
    emit(instr);
    storeIo(5);
    expected.push_back(want);
  endtask

  // One independent slot between a load and its use
  task automatic loadToIo(mipsPkg::word_t instr, mipsPkg::word_t want);
    emit(instr);
    emit(32'h0000_0000);
    storeIo(14);
    expected.push_back(want);
  endtask

  // Jump to self with a NOP in the delay slot
  task automatic emitHalt();
    emit(jFormat(mipsPkg::opJ, prog.size()));
    emit(32'h0000_0000);
  endtask

  task automatic runProgram(string name, bit withStall);
    int cycles;
    @(negedge clk);
    rst = 1'b1;
    stall = 1'b0;
    foreach (prog[i]) begin
      progWe = 1'b1;
      progAddr = i[`IMEM_WORDS_LOG2-1:0];
      progData = prog[i];
      @(negedge clk);
    end
    progWe = 1'b0;
    repeat (5) @(negedge clk);
    captured.delete();
    rst = 1'b0;
    cycles = 0;
    while (captured.size() < expected.size() && cycles < RunLimit) begin
      @(negedge clk);
      stall = withStall && (($urandom % 3) == 0);
      cycles++;
    end
    stall = 1'b0;
    // Extra cycles so that a stray strobe gets counted
    repeat (TailCycles) @(negedge clk);
    checkCount(name, captured.size(), expected.size());
    foreach (expected[i]) begin
      checkWord($sformatf("ioData[%0d] of %s", i, name), captured[i], expected[i]);
    end
    prog.delete();
    expected.delete();
  endtask

  task automatic buildAluProgram();
    mipsPkg::word_t a;
    mipsPkg::word_t b;
    a = 32'h1234_5678;
    b = 32'hF0F0_8001;
    emit(iFormat(mipsPkg::opLui, 0, 1, 16'h8000));
    emit(iFormat(mipsPkg::opLui, 0, 2, 16'h1234));
    emit(iFormat(mipsPkg::opOri, 2, 2, 16'h5678));
    emit(iFormat(mipsPkg::opLui, 0, 3, 16'hF0F0));
    emit(iFormat(mipsPkg::opOri, 3, 3, 16'h8001));
    resultToIo(rFormat(mipsPkg::fnAddu, 2, 3, 5, 0), a + b);
    resultToIo(rFormat(mipsPkg::fnSubu, 2, 3, 5, 0), a - b);
    resultToIo(rFormat(mipsPkg::fnAnd, 2, 3, 5, 0), a & b);
    resultToIo(rFormat(mipsPkg::fnOr, 2, 3, 5, 0), a | b);
    resultToIo(rFormat(mipsPkg::fnXor, 2, 3, 5, 0), a ^ b);
    resultToIo(rFormat(mipsPkg::fnNor, 2, 3, 5, 0), ~(a | b));
    // b is negative when signed, large when unsigned
    resultToIo(rFormat(mipsPkg::fnSlt, 2, 3, 5, 0), {31'b0, $signed(a) < $signed(b)});
    resultToIo(rFormat(mipsPkg::fnSlt, 3, 2, 5, 0), {31'b0, $signed(b) < $signed(a)});
    resultToIo(rFormat(mipsPkg::fnSltu, 2, 3, 5, 0), {31'b0, a < b});
    resultToIo(rFormat(mipsPkg::fnSll, 0, 3, 5, 4), b << 4);
    resultToIo(rFormat(mipsPkg::fnSrl, 0, 3, 5, 4), b >> 4);
    resultToIo(rFormat(mipsPkg::fnSra, 0, 3, 5, 4), mipsPkg::word_t'($signed(b) >>> 4));
    resultToIo(iFormat(mipsPkg::opAddiu, 2, 5, -3), a - 32'd3);
    resultToIo(iFormat(mipsPkg::opSlti, 3, 5, -1),
               {31'b0, $signed(b) < $signed(32'hFFFF_FFFF)});
    resultToIo(iFormat(mipsPkg::opSltiu, 3, 5, -1), {31'b0, b < 32'hFFFF_FFFF});
    resultToIo(iFormat(mipsPkg::opSltiu, 2, 5, 5), {31'b0, a < 32'd5});
    resultToIo(iFormat(mipsPkg::opAndi, 3, 5, 16'h8F0F), b & 32'h0000_8F0F);
    resultToIo(iFormat(mipsPkg::opOri, 2, 5, 16'hFFFF), a | 32'h0000_FFFF);
    resultToIo(iFormat(mipsPkg::opXori, 3, 5, 16'hFFFF), b ^ 32'h0000_FFFF);
    resultToIo(iFormat(mipsPkg::opLui, 0, 5, 16'hBEEF), 32'hBEEF_0000);
    emitHalt();
  endtask

  task automatic aluTest();
    buildAluProgram();
    runProgram("aluTest", 1'b0);
  endtask

  task automatic forwardTest();
    mipsPkg::word_t x;
    emit(iFormat(mipsPkg::opLui, 0, 1, 16'h8000));
    // Each instruction reads the one just before it
    emit(iFormat(mipsPkg::opAddiu, 0, 6, 7));
    emit(rFormat(mipsPkg::fnAddu, 6, 6, 6, 0));
    emit(iFormat(mipsPkg::opAddiu, 6, 6, 100));
    emit(rFormat(mipsPkg::fnSll, 0, 6, 6, 2));
    storeIo(6);
    x = 32'd7;
    x = x + x;
    x = x + 32'd100;
    expected.push_back(x << 2);
    emit(iFormat(mipsPkg::opAddiu, 0, 9, 3));
    emit(iFormat(mipsPkg::opAddiu, 0, 10, 5));
    emit(rFormat(mipsPkg::fnAddu, 9, 10, 11, 0));
    emit(rFormat(mipsPkg::fnXor, 11, 9, 11, 0));
    storeIo(11);
    expected.push_back((32'd3 + 32'd5) ^ 32'd3);
    emitHalt();
    runProgram("forwardTest", 1'b0);
  endtask

  task automatic memoryTest();
    mipsPkg::word_t memWord;
    int k;
    emit(iFormat(mipsPkg::opLui, 0, 1, 16'h8000));
    emit(iFormat(mipsPkg::opAddiu, 0, 12, 16'h0100));
    emit(iFormat(mipsPkg::opLui, 0, 13, 16'h8899));
    emit(iFormat(mipsPkg::opOri, 13, 13, 16'hAABB));
    emit(iFormat(mipsPkg::opSw, 12, 13, 0));
    memWord = 32'h8899_AABB;
    loadToIo(iFormat(mipsPkg::opLw, 12, 14, 0), memWord);
    emit(iFormat(mipsPkg::opAddiu, 0, 15, 16'h7E55));
    emit(iFormat(mipsPkg::opSh, 12, 15, 2));
    emit(iFormat(mipsPkg::opAddiu, 0, 16, -3));
    emit(iFormat(mipsPkg::opSb, 12, 16, 1));
    memWord[31:16] = 16'h7E55;
    memWord[15:8] = 8'hFD;
    // Load right behind the byte store to the same word
    loadToIo(iFormat(mipsPkg::opLw, 12, 14, 0), memWord);
    for (k = 0; k < 4; k++) begin
      loadToIo(iFormat(mipsPkg::opLb, 12, 14, k),
               {{24{memWord[8*k+7]}}, memWord[8*k +: 8]});
      loadToIo(iFormat(mipsPkg::opLbu, 12, 14, k), {24'b0, memWord[8*k +: 8]});
    end
    for (k = 0; k < 4; k += 2) begin
      loadToIo(iFormat(mipsPkg::opLh, 12, 14, k),
               {{16{memWord[8*k+15]}}, memWord[8*k +: 16]});
      loadToIo(iFormat(mipsPkg::opLhu, 12, 14, k), {16'b0, memWord[8*k +: 16]});
    end
    emitHalt();
    runProgram("memoryTest", 1'b0);
  endtask

  task automatic branchTest();
    mipsPkg::word_t jalPc;
    emit(iFormat(mipsPkg::opLui, 0, 1, 16'h8000));
    emit(iFormat(mipsPkg::opAddiu, 0, 2, 1));
    emit(iFormat(mipsPkg::opAddiu, 0, 3, 2));
    // BEQ at word 3 not taken
    emit(iFormat(mipsPkg::opBeq, 2, 3, 3));
    emit(iFormat(mipsPkg::opAddiu, 0, 4, 16'h11));
    storeIo(4);
    // BNE at word 6 taken to word 10
    emit(iFormat(mipsPkg::opBne, 2, 3, 3));
    emit(iFormat(mipsPkg::opAddiu, 0, 4, 16'h22));
    emit(iFormat(mipsPkg::opAddiu, 0, 4, 16'h33));
    storeIo(4);
    storeIo(4);
    // BEQ at word 11 taken to word 15
    emit(iFormat(mipsPkg::opBeq, 2, 2, 3));
    emit(iFormat(mipsPkg::opAddiu, 0, 5, 16'h44));
    emit(iFormat(mipsPkg::opAddiu, 0, 5, 16'h55));
    storeIo(5);
    storeIo(5);
    // BNE at word 16 not taken
    emit(iFormat(mipsPkg::opBne, 2, 2, 2));
    emit(iFormat(mipsPkg::opAddiu, 0, 6, 16'h66));
    storeIo(6);
    // J at word 19 to word 22
    emit(jFormat(mipsPkg::opJ, 22));
    emit(iFormat(mipsPkg::opAddiu, 0, 7, 16'h77));
    storeIo(0);
    storeIo(7);
    // JAL at word 23 to the routine at word 29
    jalPc = prog.size() * 4;
    emit(jFormat(mipsPkg::opJal, 29));
    emit(iFormat(mipsPkg::opAddiu, 0, 8, 16'h88));
    storeIo(31);
    storeIo(9);
    emitHalt();
    storeIo(8);
    emit(rFormat(mipsPkg::fnJr, 31, 0, 0, 0));
    emit(iFormat(mipsPkg::opAddiu, 0, 9, 16'h99));
    storeIo(0);
    expected.push_back(32'h11);
    expected.push_back(32'h22);
    expected.push_back(32'h44);
    expected.push_back(32'h66);
    expected.push_back(32'h77);
    expected.push_back(32'h88);
    expected.push_back(jalPc + 32'd8);
    expected.push_back(32'h99);
    runProgram("branchTest", 1'b0);
  endtask

  task automatic stallTest();
    buildAluProgram();
    runProgram("stallTest", 1'b1);
  endtask

  initial begin
    void'($urandom(32'h8bfe_0d66));
    clk = 1'b0;
    rst = 1'b1;
    stall = 1'b0;
    progWe = 1'b0;
    progAddr = '0;
    progData = '0;
    aluTest();
    forwardTest();
    memoryTest();
    branchTest();
    stallTest();
    $display("all tests passed");
    $finish;
  end

endmodule
